// File: soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    //////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    // One enable per byte lane
    localparam int BE_WIDTH   = DATA_WIDTH / 8;

    //////////////////////////////////////////////////
    // Address rules, inclusive base and last
    //////////////////////////////////////////////////

    localparam logic [ADDR_WIDTH-1:0] INST_SRAM_BASE = 32'h0000_0000;
    localparam logic [ADDR_WIDTH-1:0] INST_SRAM_LAST = 32'h0000_1FFF;
    localparam logic [ADDR_WIDTH-1:0] DATA_SRAM_BASE = 32'h0001_0000;
    localparam logic [ADDR_WIDTH-1:0] DATA_SRAM_LAST = 32'h0001_1FFF;
    localparam logic [ADDR_WIDTH-1:0] PERIPH_BASE    = 32'h0002_0000;
    localparam logic [ADDR_WIDTH-1:0] PERIPH_LAST    = 32'h0002_00FF;

    // SRAM depths and word index widths
    localparam int INST_SRAM_WORDS = 2048;
    localparam int DATA_SRAM_WORDS = 2048;
    localparam int INST_SRAM_AW    = $clog2(INST_SRAM_WORDS);
    localparam int DATA_SRAM_AW    = $clog2(DATA_SRAM_WORDS);

    //////////////////////////////////////////////////
    // Peripheral register map, word offsets
    //////////////////////////////////////////////////

    localparam int PERIPH_OFFSET_WIDTH = 6;
    localparam logic [PERIPH_OFFSET_WIDTH-1:0] REG_GPIO     = 6'h00;
    localparam logic [PERIPH_OFFSET_WIDTH-1:0] REG_SCRATCH0 = 6'h04;
    localparam logic [PERIPH_OFFSET_WIDTH-1:0] REG_SCRATCH2 = 6'h0C;
    localparam logic [PERIPH_OFFSET_WIDTH-1:0] REG_ID       = 6'h10;

    // Scratch bank spread evenly from first to last slot
    localparam int SCRATCH_COUNT = 3;
    localparam logic [PERIPH_OFFSET_WIDTH-1:0] SCRATCH_STRIDE =
        PERIPH_OFFSET_WIDTH'((REG_SCRATCH2 - REG_SCRATCH0) / (SCRATCH_COUNT - 1));

    // Fixed read values
    localparam logic [DATA_WIDTH-1:0] PERIPH_ID_VALUE = 32'h50C0_0001;
    localparam logic [DATA_WIDTH-1:0] BUS_ERR_DATA    = 32'hDEAD_BEEF;

    // Target select, TGT_NONE marks an unmapped access
    typedef enum logic [1:0] {
        TGT_INST,
        TGT_DATA,
        TGT_PERIPH,
        TGT_NONE
    } target_sel_e;

endpackage

`default_nettype wire

// File: data_req_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module data_req_bridge (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic                                req_i,
    input  logic                                we_i,
    input  logic                                rvalid_i,
    input  logic [soc_bus_pkg::BE_WIDTH-1:0]    be_i,
    input  logic [soc_bus_pkg::ADDR_WIDTH-1:0]  addr_i,
    input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  wdata_i,
    output logic                                gnt_o,
    output logic                                issue_o,
    output logic                                we_o,
    output logic [soc_bus_pkg::BE_WIDTH-1:0]    be_o,
    output logic [soc_bus_pkg::ADDR_WIDTH-1:0]  addr_o,
    output logic [soc_bus_pkg::DATA_WIDTH-1:0]  wdata_o
);

    // Access in flight, blocks further grants
    logic                                outstanding_q;
    // One-cycle issue toward the targets
    logic                                issue_q;
    logic                                we_q;
    logic [soc_bus_pkg::BE_WIDTH-1:0]    be_q;
    logic [soc_bus_pkg::ADDR_WIDTH-1:0]  addr_q;
    logic [soc_bus_pkg::DATA_WIDTH-1:0]  wdata_q;
    logic                                accept;

    // Handshake completes on req while idle
    assign accept = req_i & ~outstanding_q;

    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i) begin
            outstanding_q <= 1'b0;
            issue_q       <= 1'b0;
        end else begin
            // Set on accept, cleared by the response pulse
            if (accept) begin
                outstanding_q <= 1'b1;
            end else if (rvalid_i) begin
                outstanding_q <= 1'b0;
            end
            issue_q <= accept;
        end
    end

    // Request fields held until the next accept
    always_ff @(posedge clk_i) begin
        if (accept) begin
            we_q    <= we_i;
            be_q    <= be_i;
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
        end
    end

    assign gnt_o   = ~outstanding_q;
    assign issue_o = issue_q;
    assign we_o    = we_q;
    assign be_o    = be_q;
    assign addr_o  = addr_q;
    assign wdata_o = wdata_q;

endmodule

`default_nettype wire

// File: addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module addr_decoder (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic                                issue_i,
    input  logic [soc_bus_pkg::ADDR_WIDTH-1:0]  addr_i,
    output logic                                inst_en_o,
    output logic                                data_en_o,
    output logic                                periph_en_o,
    output soc_bus_pkg::target_sel_e            sel_o
);

    logic                      inst_hit;
    logic                      data_hit;
    logic                      periph_hit;
    soc_bus_pkg::target_sel_e  sel_q;

    // Inclusive range check, offset form also covers a zero base
    function automatic logic rule_match(
        input logic [soc_bus_pkg::ADDR_WIDTH-1:0] addr,
        input logic [soc_bus_pkg::ADDR_WIDTH-1:0] base,
        input logic [soc_bus_pkg::ADDR_WIDTH-1:0] last
    );
        return (addr - base) <= (last - base);
    endfunction

    assign inst_hit   = rule_match(addr_i, soc_bus_pkg::INST_SRAM_BASE,
                                   soc_bus_pkg::INST_SRAM_LAST);
    assign data_hit   = rule_match(addr_i, soc_bus_pkg::DATA_SRAM_BASE,
                                   soc_bus_pkg::DATA_SRAM_LAST);
    assign periph_hit = rule_match(addr_i, soc_bus_pkg::PERIPH_BASE,
                                   soc_bus_pkg::PERIPH_LAST);

    // Target strobes only during the issue cycle
    assign inst_en_o   = issue_i & inst_hit;
    assign data_en_o   = issue_i & data_hit;
    assign periph_en_o = issue_i & periph_hit;

    // Select kept for the result stage one cycle later
    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i) begin
            sel_q <= soc_bus_pkg::TGT_NONE;
        end else if (issue_i) begin
            if (inst_hit) begin
                sel_q <= soc_bus_pkg::TGT_INST;
            end else if (data_hit) begin
                sel_q <= soc_bus_pkg::TGT_DATA;
            end else if (periph_hit) begin
                sel_q <= soc_bus_pkg::TGT_PERIPH;
            end else begin
                sel_q <= soc_bus_pkg::TGT_NONE;
            end
        end
    end

    assign sel_o = sel_q;

endmodule

`default_nettype wire

// File: sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank #(
    parameter int DEPTH_WORDS = 2048
) (
    input  logic                                clk_i,
    input  logic                                en_i,
    input  logic                                we_i,
    input  logic [soc_bus_pkg::BE_WIDTH-1:0]    be_i,
    input  logic [$clog2(DEPTH_WORDS)-1:0]      word_addr_i,
    input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  wdata_i,
    output logic [soc_bus_pkg::DATA_WIDTH-1:0]  rdata_o
);

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    // Word array, contents undefined after power-up
    logic [soc_bus_pkg::DATA_WIDTH-1:0] mem [DEPTH_WORDS];

    // Registered read port
    logic [soc_bus_pkg::DATA_WIDTH-1:0] rdata_q;

    //////////////////////////////////////////////////
    // Access port
    //////////////////////////////////////////////////

    // Byte-lane writes
    always_ff @(posedge clk_i) begin
        if (en_i && we_i) begin
            for (int b = 0; b < soc_bus_pkg::BE_WIDTH; b++) begin
                if (be_i[b]) begin
                    mem[word_addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Read data lands one cycle after the enable
    // and holds across writes
    always_ff @(posedge clk_i) begin
        if (en_i && !we_i) begin
            rdata_q <= mem[word_addr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: periph_regs.sv
`timescale 1ns/1ps
`default_nettype none

module periph_regs (
    input  logic                                        clk_i,
    input  logic                                        reset_i,
    input  logic                                        en_i,
    input  logic                                        we_i,
    input  logic [soc_bus_pkg::BE_WIDTH-1:0]            be_i,
    input  logic [soc_bus_pkg::PERIPH_OFFSET_WIDTH-1:0] offset_i,
    input  logic [soc_bus_pkg::DATA_WIDTH-1:0]          wdata_i,
    output logic [soc_bus_pkg::DATA_WIDTH-1:0]          rdata_o,
    output logic [soc_bus_pkg::DATA_WIDTH-1:0]          gpio_o
);

    logic [soc_bus_pkg::DATA_WIDTH-1:0]    gpio_q;
    logic [soc_bus_pkg::DATA_WIDTH-1:0]    scratch_q [soc_bus_pkg::SCRATCH_COUNT];
    logic [soc_bus_pkg::SCRATCH_COUNT-1:0] scratch_hit;
    logic [soc_bus_pkg::DATA_WIDTH-1:0]    rd_word;
    logic [soc_bus_pkg::DATA_WIDTH-1:0]    rdata_q;

    // Keep old bytes where the lane is disabled
    function automatic logic [soc_bus_pkg::DATA_WIDTH-1:0] byte_merge(
        input logic [soc_bus_pkg::DATA_WIDTH-1:0] old_word,
        input logic [soc_bus_pkg::DATA_WIDTH-1:0] new_word,
        input logic [soc_bus_pkg::BE_WIDTH-1:0]   be
    );
        logic [soc_bus_pkg::DATA_WIDTH-1:0] merged;
        merged = old_word;
        for (int b = 0; b < soc_bus_pkg::BE_WIDTH; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // Scratch slot decode, walking the stride from the first slot
    always_comb begin
        logic [soc_bus_pkg::PERIPH_OFFSET_WIDTH-1:0] slot;
        slot = soc_bus_pkg::REG_SCRATCH0;
        for (int i = 0; i < soc_bus_pkg::SCRATCH_COUNT; i++) begin
            scratch_hit[i] = (offset_i == slot);
            slot           = slot + soc_bus_pkg::SCRATCH_STRIDE;
        end
    end

    // Read map, holes read as zero
    always_comb begin
        rd_word = '0;
        if (offset_i == soc_bus_pkg::REG_GPIO) begin
            rd_word = gpio_q;
        end
        if (offset_i == soc_bus_pkg::REG_ID) begin
            rd_word = soc_bus_pkg::PERIPH_ID_VALUE;
        end
        for (int i = 0; i < soc_bus_pkg::SCRATCH_COUNT; i++) begin
            if (scratch_hit[i]) begin
                rd_word = scratch_q[i];
            end
        end
    end

    // Writable registers; ID and holes drop writes
    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i) begin
            gpio_q    <= '0;
            scratch_q <= '{default: '0};
        end else if (en_i && we_i) begin
            if (offset_i == soc_bus_pkg::REG_GPIO) begin
                gpio_q <= byte_merge(gpio_q, wdata_i, be_i);
            end
            for (int i = 0; i < soc_bus_pkg::SCRATCH_COUNT; i++) begin
                if (scratch_hit[i]) begin
                    scratch_q[i] <= byte_merge(scratch_q[i], wdata_i, be_i);
                end
            end
        end
    end

    // Read data registered, same latency as the SRAMs
    always_ff @(posedge clk_i) begin
        if (en_i && !we_i) begin
            rdata_q <= rd_word;
        end
    end

    assign rdata_o = rdata_q;
    assign gpio_o  = gpio_q;

endmodule

`default_nettype wire

// File: response_mux.sv
`timescale 1ns/1ps
`default_nettype none

module response_mux (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic                                issue_i,
    input  soc_bus_pkg::target_sel_e            sel_i,
    input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  inst_rdata_i,
    input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  data_rdata_i,
    input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  periph_rdata_i,
    output logic                                rvalid_o,
    output logic                                err_o,
    output logic [soc_bus_pkg::DATA_WIDTH-1:0]  rdata_o
);

    // Response valid, one cycle behind the issue
    logic rvalid_q;

    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= issue_i;
        end
    end

    // Read data by registered select
    always_comb begin
        case (sel_i)
            soc_bus_pkg::TGT_INST: begin
                rdata_o = inst_rdata_i;
            end
            soc_bus_pkg::TGT_DATA: begin
                rdata_o = data_rdata_i;
            end
            soc_bus_pkg::TGT_PERIPH: begin
                rdata_o = periph_rdata_i;
            end
            default: begin
                // Unmapped, decode error word
                rdata_o = soc_bus_pkg::BUS_ERR_DATA;
            end
        endcase
    end

    assign rvalid_o = rvalid_q;
    // Error only qualified by the response pulse
    assign err_o    = rvalid_q && (sel_i == soc_bus_pkg::TGT_NONE);

endmodule

`default_nettype wire

// File: soc_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic                                req_i,
    input  logic                                we_i,
    input  logic [soc_bus_pkg::BE_WIDTH-1:0]    be_i,
    input  logic [soc_bus_pkg::ADDR_WIDTH-1:0]  addr_i,
    input  logic [soc_bus_pkg::DATA_WIDTH-1:0]  wdata_i,
    output logic                                gnt_o,
    output logic                                rvalid_o,
    output logic                                err_o,
    output logic [soc_bus_pkg::DATA_WIDTH-1:0]  rdata_o,
    output logic [soc_bus_pkg::DATA_WIDTH-1:0]  gpio_o
);

    //////////////////////////////////////////////////
    // Internal nets
    //////////////////////////////////////////////////

    // Registered request from the bridge
    logic                                issue;
    logic                                req_we;
    logic [soc_bus_pkg::BE_WIDTH-1:0]    req_be;
    logic [soc_bus_pkg::ADDR_WIDTH-1:0]  req_addr;
    logic [soc_bus_pkg::DATA_WIDTH-1:0]  req_wdata;

    // Decode results
    logic                                inst_en;
    logic                                data_en;
    logic                                periph_en;
    soc_bus_pkg::target_sel_e            sel;

    // Target read data
    logic [soc_bus_pkg::DATA_WIDTH-1:0]  inst_rdata;
    logic [soc_bus_pkg::DATA_WIDTH-1:0]  data_rdata;
    logic [soc_bus_pkg::DATA_WIDTH-1:0]  periph_rdata;

    //////////////////////////////////////////////////
    // Request capture and decode
    //////////////////////////////////////////////////

    data_req_bridge u_bridge (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (req_i),
        .we_i      (we_i),
        .rvalid_i  (rvalid_o),
        .be_i      (be_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .gnt_o     (gnt_o),
        .issue_o   (issue),
        .we_o      (req_we),
        .be_o      (req_be),
        .addr_o    (req_addr),
        .wdata_o   (req_wdata)
    );

    addr_decoder u_decoder (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .issue_i     (issue),
        .addr_i      (req_addr),
        .inst_en_o   (inst_en),
        .data_en_o   (data_en),
        .periph_en_o (periph_en),
        .sel_o       (sel)
    );

    //////////////////////////////////////////////////
    // Targets, word index from address bit 2 up
    //////////////////////////////////////////////////

    sram_bank #(
        .DEPTH_WORDS (soc_bus_pkg::INST_SRAM_WORDS)
    ) u_inst_sram (
        .clk_i       (clk_i),
        .en_i        (inst_en),
        .we_i        (req_we),
        .be_i        (req_be),
        .word_addr_i (req_addr[soc_bus_pkg::INST_SRAM_AW+1:2]),
        .wdata_i     (req_wdata),
        .rdata_o     (inst_rdata)
    );

    sram_bank #(
        .DEPTH_WORDS (soc_bus_pkg::DATA_SRAM_WORDS)
    ) u_data_sram (
        .clk_i       (clk_i),
        .en_i        (data_en),
        .we_i        (req_we),
        .be_i        (req_be),
        .word_addr_i (req_addr[soc_bus_pkg::DATA_SRAM_AW+1:2]),
        .wdata_i     (req_wdata),
        .rdata_o     (data_rdata)
    );

    periph_regs u_periph (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .en_i     (periph_en),
        .we_i     (req_we),
        .be_i     (req_be),
        .offset_i (req_addr[soc_bus_pkg::PERIPH_OFFSET_WIDTH+1:2]),
        .wdata_i  (req_wdata),
        .rdata_o  (periph_rdata),
        .gpio_o   (gpio_o)
    );

    // Result stage back to the core port
    response_mux u_response (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .issue_i        (issue),
        .sel_i          (sel),
        .inst_rdata_i   (inst_rdata),
        .data_rdata_i   (data_rdata),
        .periph_rdata_i (periph_rdata),
        .rvalid_o       (rvalid_o),
        .err_o          (err_o),
        .rdata_o        (rdata_o)
    );

endmodule

`default_nettype wire

// File: tb_soc_bus_checks.svh
`ifndef TB_SOC_BUS_CHECKS_SVH
`define TB_SOC_BUS_CHECKS_SVH

//////////////////////////////////////////////////
// Random source
//////////////////////////////////////////////////

// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
logic [15:0] lfsr_state = 16'd44280;

// One LFSR step per bit, output bit shifted in from the right
function automatic logic [31:0] take_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
        value = {value[30:0], lfsr_state[0]};
        if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
        end else begin
            lfsr_state = lfsr_state >> 1;
        end
    end
    return value;
endfunction

//////////////////////////////////////////////////
// Compare and bounded waits
//////////////////////////////////////////////////

int check_count   = 0;
int error_count   = 0;
int timeout_count = 0;

localparam int WAIT_LIMIT = 32;

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

// Grant wait, counted in falling edges
task automatic wait_grant(output int cycles, output bit ok);
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < WAIT_LIMIT) begin
        @(negedge clk);
        cycles++;
        // Idle bus carries no response
        check_value("rvalid_o", 32'(rvalid), 32'd0);
        ok = (gnt === 1'b1);
    end
    if (!ok) begin
        timeout_count++;
        $display("Timeout at %0t: the request never got a grant", $time);
    end
endtask

// Response wait, grant must stay low meanwhile
task automatic wait_response(output int cycles, output bit ok);
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < WAIT_LIMIT) begin
        @(negedge clk);
        cycles++;
        check_value("gnt_o", 32'(gnt), 32'd0);
        ok = (rvalid === 1'b1);
    end
    if (!ok) begin
        timeout_count++;
        $display("Timeout at %0t: an accepted request never got a response", $time);
    end
endtask

`endif

// File: tb_soc_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus_top;

    localparam int ACCESS_COUNT = 400;

    // DUT side
    logic        clk;
    logic        reset;
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
    logic [31:0] gpio;

    // Model state with SRAMs keyed by byte offset in the bank
    logic [7:0]  inst_model [int];
    logic [7:0]  data_model [int];
    logic [31:0] gpio_model;
    logic [31:0] scratch_model [3];
    bit          hung;

    `include "tb_soc_bus_checks.svh"

    always #5 clk = ~clk;

    soc_bus_top u_soc_bus_top (
        .clk_i   (clk),
        .reset_i (reset),
        .req_i   (req),
        .we_i    (we),
        .be_i    (be),
        .addr_i  (addr),
        .wdata_i (wdata),
        .gnt_o   (gnt),
        .rvalid_o(rvalid),
        .err_o   (err),
        .rdata_o (rdata),
        .gpio_o  (gpio)
    );

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic bit in_rule(input logic [31:0] a, input logic [31:0] base,
                                   input logic [31:0] last);
        return (a >= base) && (a <= last);
    endfunction

    // 0 inst SRAM, 1 data SRAM, 2 peripherals, 3 unmapped
    function automatic int region_of(input logic [31:0] a);
        if (in_rule(a, soc_bus_pkg::INST_SRAM_BASE, soc_bus_pkg::INST_SRAM_LAST)) begin
            return 0;
        end
        if (in_rule(a, soc_bus_pkg::DATA_SRAM_BASE, soc_bus_pkg::DATA_SRAM_LAST)) begin
            return 1;
        end
        if (in_rule(a, soc_bus_pkg::PERIPH_BASE, soc_bus_pkg::PERIPH_LAST)) begin
            return 2;
        end
        return 3;
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] bmask);
        return {{8{bmask[3]}}, {8{bmask[2]}}, {8{bmask[1]}}, {8{bmask[0]}}};
    endfunction

    function automatic logic [31:0] periph_addr(input logic [5:0] off);
        return soc_bus_pkg::PERIPH_BASE + {24'b0, off, 2'b00};
    endfunction

    // Expected read word with a mask that clears bytes never written
    function automatic void expect_read(input logic [31:0] a, output logic [31:0] exp_data,
                                        output logic [31:0] mask);
        int region;
        int key;
        region   = region_of(a);
        exp_data = '0;
        mask     = '1;
        if (region == 0 || region == 1) begin
            mask = '0;
            key  = (region == 0) ? int'(a - soc_bus_pkg::INST_SRAM_BASE)
                                 : int'(a - soc_bus_pkg::DATA_SRAM_BASE);
            for (int b = 0; b < 4; b++) begin
                if (region == 0 && inst_model.exists(key + b)) begin
                    exp_data[8*b +: 8] = inst_model[key + b];
                    mask[8*b +: 8]     = 8'hFF;
                end
                if (region == 1 && data_model.exists(key + b)) begin
                    exp_data[8*b +: 8] = data_model[key + b];
                    mask[8*b +: 8]     = 8'hFF;
                end
            end
        end else if (region == 2) begin
            case (a[7:2])
                soc_bus_pkg::REG_GPIO:     exp_data = gpio_model;
                soc_bus_pkg::REG_SCRATCH0: exp_data = scratch_model[0];
                6'h08:                     exp_data = scratch_model[1];
                soc_bus_pkg::REG_SCRATCH2: exp_data = scratch_model[2];
                soc_bus_pkg::REG_ID:       exp_data = soc_bus_pkg::PERIPH_ID_VALUE;
                default:                   exp_data = '0;
            endcase
        end else begin
            exp_data = soc_bus_pkg::BUS_ERR_DATA;
        end
    endfunction

    function automatic void apply_write(input logic [31:0] a, input logic [31:0] d,
                                        input logic [3:0] bmask);
        int          region;
        int          key;
        logic [31:0] m;
        region = region_of(a);
        m      = lane_mask(bmask);
        if (region == 0 || region == 1) begin
            key = (region == 0) ? int'(a - soc_bus_pkg::INST_SRAM_BASE)
                                : int'(a - soc_bus_pkg::DATA_SRAM_BASE);
            for (int b = 0; b < 4; b++) begin
                if (bmask[b] && region == 0) inst_model[key + b] = d[8*b +: 8];
                if (bmask[b] && region == 1) data_model[key + b] = d[8*b +: 8];
            end
        end else if (region == 2) begin
            // ID and holes drop the write
            case (a[7:2])
                soc_bus_pkg::REG_GPIO:     gpio_model = (gpio_model & ~m) | (d & m);
                soc_bus_pkg::REG_SCRATCH0: scratch_model[0] = (scratch_model[0] & ~m) | (d & m);
                6'h08:                     scratch_model[1] = (scratch_model[1] & ~m) | (d & m);
                soc_bus_pkg::REG_SCRATCH2: scratch_model[2] = (scratch_model[2] & ~m) | (d & m);
                default: ;
            endcase
        end
    endfunction

    //////////////////////////////////////////////////
    // Bus access
    //////////////////////////////////////////////////

    // Entered and left 1 ns after a rising edge
    // With hold set the same request stays up behind the one in flight
    task automatic do_access(input logic wr, input logic [3:0] bmask,
                             input logic [31:0] a, input logic [31:0] d,
                             input logic hold);
        int          lat;
        bit          ok;
        int          region;
        logic [31:0] exp_data;
        logic [31:0] mask;
        if (hung) return;
        region = region_of(a);
        req    = 1'b1;
        we     = wr;
        be     = bmask;
        addr   = a;
        wdata  = d;
        wait_grant(lat, ok);
        if (!ok) begin
            hung = 1'b1;
            return;
        end
        // Grant already up at the first falling edge
        check_value("gnt_o latency", 32'(lat), 32'd1);
        @(posedge clk);
        #1;
        req = hold;
        wait_response(lat, ok);
        if (!ok) begin
            hung = 1'b1;
            return;
        end
        check_value("rvalid_o latency", 32'(lat), 32'd2);
        check_value("err_o", 32'(err), 32'(region == 3));
        if (region == 3 || !wr) begin
            expect_read(a, exp_data, mask);
            check_value("rdata_o", rdata & mask, exp_data & mask);
        end else begin
            apply_write(a, d, bmask);
        end
        check_value("gpio_o", gpio, gpio_model);
        @(posedge clk);
        #1;
    endtask

    task automatic random_access();
        logic [1:0]  region;
        logic        wr;
        logic [3:0]  bmask;
        logic [31:0] d;
        logic [31:0] a;
        logic [10:0] word;
        logic [5:0]  off;
        logic [1:0]  pick;
        logic        held;
        region = 2'(take_bits(2));
        wr     = 1'(take_bits(1));
        bmask  = 4'(take_bits(4));
        d      = take_bits(32);
        word   = 11'(take_bits(5));
        // Top four indices go to the end of the bank
        if (word >= 11'd28) word = word + 11'd2016;
        case (region)
            2'd0: a = soc_bus_pkg::INST_SRAM_BASE + {19'b0, word, 2'b00};
            2'd1: a = soc_bus_pkg::DATA_SRAM_BASE + {19'b0, word, 2'b00};
            2'd2: begin
                // Half the time one of the defined registers
                if (take_bits(1) == 32'd1) begin
                    off = 6'(32'd4 * (take_bits(3) % 32'd5));
                end else begin
                    off = 6'(take_bits(6));
                end
                a = periph_addr(off);
            end
            default: begin
                pick = 2'(take_bits(2));
                case (pick)
                    2'd0:    a = soc_bus_pkg::INST_SRAM_LAST + 32'd1;
                    2'd1:    a = soc_bus_pkg::DATA_SRAM_LAST + 32'd1;
                    2'd2:    a = soc_bus_pkg::PERIPH_LAST + 32'd1;
                    default: a = {1'b1, 29'(take_bits(29)), 2'b00};
                endcase
            end
        endcase
        // One access in four repeats while the first is still in flight
        held = (take_bits(2) == 32'd0);
        if (held) begin
            do_access(wr, bmask, a, d, 1'b1);
        end
        do_access(wr, bmask, a, d, 1'b0);
    endtask

    //////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        req           = 1'b0;
        we            = 1'b0;
        be            = '0;
        addr          = '0;
        wdata         = '0;
        hung          = 1'b0;
        gpio_model    = '0;
        scratch_model = '{default: '0};
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        // Idle state out of reset
        @(negedge clk);
        check_value("gnt_o", 32'(gnt), 32'd1);
        check_value("rvalid_o", 32'(rvalid), 32'd0);
        check_value("err_o", 32'(err), 32'd0);
        check_value("gpio_o", gpio, 32'd0);
        @(posedge clk);
        #1;
        // Same offset in both banks, then a partial write
        do_access(1'b1, 4'hF, soc_bus_pkg::INST_SRAM_BASE + 32'h20, 32'h1111_2222, 1'b0);
        do_access(1'b1, 4'hF, soc_bus_pkg::DATA_SRAM_BASE + 32'h20, 32'h3333_4444, 1'b0);
        do_access(1'b1, 4'h5, soc_bus_pkg::DATA_SRAM_BASE + 32'h20, 32'hAAAA_BBBB, 1'b0);
        do_access(1'b0, 4'hF, soc_bus_pkg::INST_SRAM_BASE + 32'h20, 32'h0, 1'b0);
        do_access(1'b0, 4'hF, soc_bus_pkg::DATA_SRAM_BASE + 32'h20, 32'h0, 1'b0);
        // ID is read-only, GPIO takes a byte merge
        do_access(1'b1, 4'hF, periph_addr(soc_bus_pkg::REG_ID), 32'hFFFF_FFFF, 1'b0);
        do_access(1'b0, 4'hF, periph_addr(soc_bus_pkg::REG_ID), 32'h0, 1'b1);
        do_access(1'b0, 4'hF, periph_addr(soc_bus_pkg::REG_ID), 32'h0, 1'b0);
        do_access(1'b1, 4'h3, periph_addr(soc_bus_pkg::REG_GPIO), 32'hCAFE_F00D, 1'b0);
        do_access(1'b1, 4'hF, soc_bus_pkg::PERIPH_LAST + 32'd1, 32'h0BAD_0BAD, 1'b0);
        for (int n = 0; n < ACCESS_COUNT && !hung; n++) begin
            random_access();
        end
        // Bus returns to idle after the last response
        if (!hung) begin
            @(negedge clk);
            check_value("rvalid_o", 32'(rvalid), 32'd0);
            check_value("gnt_o", 32'(gnt), 32'd1);
        end
        $display("Checks %0d, errors %0d, timeouts %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
soc_bus_pkg.sv
data_req_bridge.sv
addr_decoder.sv
sram_bank.sv
periph_regs.sv
response_mux.sv
soc_bus_top.sv
tb_soc_bus_top.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line shows up

verilator --binary -f tb.f --top-module tb_soc_bus_top -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q -F "Simulation finished: PASS" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
